// File: run.sh
#!/bin/bash
# build and run the execUnit testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter project directory"
	exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module execUnit_tb -f vlog.f -o simExec
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/simExec > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "ALL TESTS PASSED" sim.log; then
	exit 0
fi
exit 1

// File: src/aluUnit.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module aluUnit import execPkg::*;
(
	input aluOpT op,
	input logic [`RV_XLEN-1:0] x,
	input logic [`RV_XLEN-1:0] y,
	output logic [`RV_XLEN-1:0] result
);

	logic [4:0] shamt;

	assign shamt = y[4:0];

	always_comb
	begin
		result = '0;
		case (op)
			aluAdd: result = x + y;
			aluSub: result = x - y;
			aluSll: result = x << shamt;
			aluSlt: result[0] = $signed(x) < $signed(y);
			aluSltu: result[0] = x < y;
			aluXor: result = x ^ y;
			aluSrl: result = x >> shamt;
			aluSra: result = $signed(x) >>> shamt; // keeps the sign bit
			aluOr: result = x | y;
			aluAnd: result = x & y;
			aluEq: result[0] = x == y;
			aluNe: result[0] = x != y;
			aluGe: result[0] = $signed(x) >= $signed(y);
			aluGeu: result[0] = x >= y;
			default: result = '0;
		endcase
	end

endmodule

// File: src/commitPort.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module commitPort
(
	input logic clk,
	input logic reset,
	input logic load,
	input logic [`RV_REGW-1:0] recRd,
	input logic [`RV_XLEN-1:0] recData,
	input logic recRegWrite,
	input logic recPcWrite,
	input logic [`RV_XLEN-1:0] recPcTarget,
	output logic bufFree,
	output logic [`RV_REGW-1:0] bufRd,
	output logic [`RV_XLEN-1:0] bufData,
	output logic bufRegWrite,
	output logic outReq,
	input logic outAck,
	output logic [`RV_REGW-1:0] commitRd,
	output logic [`RV_XLEN-1:0] commitData,
	output logic commitRegWrite,
	output logic pcWriteEnable,
	output logic [`RV_XLEN-1:0] pcWriteData,
	output logic wEn,
	output logic [`RV_REGW-1:0] wAddr,
	output logic [`RV_XLEN-1:0] wData
);

	typedef enum logic [1:0] {sIdle, sReq, sAckLow} sendStateT;

	sendStateT state;
	logic bufPcWrite;
	logic [`RV_XLEN-1:0] bufPcTarget;
	logic accept;

	assign accept = (state == sReq) && outAck; // first cycle of ack

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sIdle;
			bufRegWrite <= 1'b0;
		end
		else
		begin
			case (state)
				sIdle:
					if (load)
					begin
						state <= sReq;
						bufRegWrite <= recRegWrite && recRd != '0; // x0 never forwards
					end
				sReq:
					if (outAck)
					begin
						state <= sAckLow;
						bufRegWrite <= 1'b0; // value now in the register file
					end
				default:
					if (!outAck)
						state <= sIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (load && state == sIdle)
		begin
			bufRd <= recRd;
			bufData <= recData;
			bufPcWrite <= recPcWrite;
			bufPcTarget <= recPcTarget;
		end
	end

	assign bufFree = (state == sIdle);
	assign outReq = (state == sReq);

	assign commitRd = bufRd;
	assign commitData = bufData;
	assign commitRegWrite = bufRegWrite;
	assign pcWriteEnable = bufPcWrite;
	assign pcWriteData = bufPcTarget;

	assign wEn = accept && bufRegWrite;
	assign wAddr = bufRd;
	assign wData = bufData;

endmodule

// File: src/execCore.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module execCore import execPkg::*;
(
	input logic issueValid,
	output logic issueTake,
	input aluOpT aluOp,
	input commitKindT kind,
	input logic useImm,
	input logic usePc,
	input logic [`RV_REGW-1:0] rs1Q,
	input logic [`RV_REGW-1:0] rs2Q,
	input logic [`RV_REGW-1:0] rdQ,
	input logic [`RV_XLEN-1:0] immQ,
	input logic [`RV_XLEN-1:0] pcQ,
	output logic [`RV_REGW-1:0] rAddr0,
	output logic [`RV_REGW-1:0] rAddr1,
	input logic [`RV_XLEN-1:0] rData0,
	input logic [`RV_XLEN-1:0] rData1,
	input logic bufFree,
	input logic [`RV_REGW-1:0] bufRd,
	input logic [`RV_XLEN-1:0] bufData,
	input logic bufRegWrite,
	output logic load,
	output logic [`RV_REGW-1:0] recRd,
	output logic [`RV_XLEN-1:0] recData,
	output logic recRegWrite,
	output logic recPcWrite,
	output logic [`RV_XLEN-1:0] recPcTarget
);

	logic [`RV_XLEN-1:0] rs1Val, rs2Val;
	logic [`RV_XLEN-1:0] opA, opB, aluResult;
	logic [`RV_XLEN-1:0] pcPlus4, branchTarget, jalrSum;

	assign rAddr0 = rs1Q;
	assign rAddr1 = rs2Q;

	// buffered result not yet in the register file wins
	assign rs1Val = (bufRegWrite && bufRd == rs1Q) ? bufData : rData0;
	assign rs2Val = (bufRegWrite && bufRd == rs2Q) ? bufData : rData1;

	assign opA = usePc ? pcQ : rs1Val;
	assign opB = useImm ? immQ : rs2Val;

	aluUnit alu_i (.op(aluOp), .x(opA), .y(opB), .result(aluResult));

	// jump adders, separate from the alu
	assign pcPlus4 = pcQ + `RV_XLEN'd4;
	assign branchTarget = pcQ + immQ;
	assign jalrSum = rs1Val + immQ;

	assign issueTake = issueValid && bufFree;
	assign load = issueTake;

	always_comb
	begin
		recRd = '0;
		recData = '0;
		recRegWrite = 1'b0;
		recPcWrite = 1'b0;
		recPcTarget = '0;
		case (kind)
			kindReg:
			begin
				recRd = rdQ;
				recData = aluResult;
				recRegWrite = 1'b1;
			end
			kindLui:
			begin
				recRd = rdQ;
				recData = immQ;
				recRegWrite = 1'b1;
			end
			kindBranch:
			begin
				recPcWrite = aluResult[0]; // comparison outcome
				recPcTarget = branchTarget;
			end
			kindJal, kindJalr:
			begin
				recRd = rdQ;
				recData = pcPlus4; // link address
				recRegWrite = 1'b1;
				recPcWrite = 1'b1;
				recPcTarget = (kind == kindJal) ? branchTarget
					: {jalrSum[`RV_XLEN-1:1], 1'b0};
			end
			default: recPcWrite = 1'b0; // unknown, empty record
		endcase
	end

endmodule

// File: src/execPkg.sv
package execPkg;

	// alu operations, comparisons return 0 or 1 in bit 0
	typedef enum logic [3:0]
	{
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluEq,
		aluNe,
		aluGe,
		aluGeu
	} aluOpT;

	// what the commit record does with the result
	typedef enum logic [2:0]
	{
		kindNone, // unknown opcode, no effect
		kindReg, // alu result to rd
		kindLui, // immediate to rd
		kindBranch, // pc write if comparison holds
		kindJal, // pc + imm, rd gets pc + 4
		kindJalr // rs1 + imm with bit 0 cleared
	} commitKindT;

endpackage

// File: src/execUnit.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module execUnit import execPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inReq,
	output logic inAck,
	input logic [`RV_OPW-1:0] opcode,
	input logic [2:0] func3,
	input logic [6:0] func7,
	input logic [`RV_REGW-1:0] rs1,
	input logic [`RV_REGW-1:0] rs2,
	input logic [`RV_REGW-1:0] rd,
	input logic [`RV_XLEN-1:0] imm,
	input logic [`RV_XLEN-1:0] pc,
	output logic outReq,
	input logic outAck,
	output logic [`RV_REGW-1:0] commitRd,
	output logic [`RV_XLEN-1:0] commitData,
	output logic commitRegWrite,
	output logic pcWriteEnable,
	output logic [`RV_XLEN-1:0] pcWriteData
);

	// intake to core
	logic issueValid, issueTake, useImm, usePc;
	aluOpT aluOp;
	commitKindT kind;
	logic [`RV_REGW-1:0] rs1Q, rs2Q, rdQ;
	logic [`RV_XLEN-1:0] immQ, pcQ;

	// register file ports
	logic [`RV_REGW-1:0] rAddr0, rAddr1, wAddr;
	logic [`RV_XLEN-1:0] rData0, rData1, wData;
	logic wEn;

	// core to commit buffer and back
	logic load, recRegWrite, recPcWrite;
	logic [`RV_REGW-1:0] recRd;
	logic [`RV_XLEN-1:0] recData, recPcTarget;
	logic bufFree, bufRegWrite;
	logic [`RV_REGW-1:0] bufRd;
	logic [`RV_XLEN-1:0] bufData;

	instrIntake intake_i (
		.clk(clk), .reset(reset), .inReq(inReq), .inAck(inAck),
		.opcode(opcode), .func3(func3), .func7(func7),
		.rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .pc(pc),
		.issueValid(issueValid), .issueTake(issueTake),
		.aluOp(aluOp), .kind(kind), .useImm(useImm), .usePc(usePc),
		.rs1Q(rs1Q), .rs2Q(rs2Q), .rdQ(rdQ), .immQ(immQ), .pcQ(pcQ)
	);

	execCore core_i (
		.issueValid(issueValid), .issueTake(issueTake),
		.aluOp(aluOp), .kind(kind), .useImm(useImm), .usePc(usePc),
		.rs1Q(rs1Q), .rs2Q(rs2Q), .rdQ(rdQ), .immQ(immQ), .pcQ(pcQ),
		.rAddr0(rAddr0), .rAddr1(rAddr1), .rData0(rData0), .rData1(rData1),
		.bufFree(bufFree), .bufRd(bufRd), .bufData(bufData), .bufRegWrite(bufRegWrite),
		.load(load), .recRd(recRd), .recData(recData), .recRegWrite(recRegWrite),
		.recPcWrite(recPcWrite), .recPcTarget(recPcTarget)
	);

	regFile regs_i (
		.clk(clk), .reset(reset),
		.rAddr0(rAddr0), .rAddr1(rAddr1), .rData0(rData0), .rData1(rData1),
		.wEn(wEn), .wAddr(wAddr), .wData(wData)
	);

	commitPort commit_i (
		.clk(clk), .reset(reset), .load(load),
		.recRd(recRd), .recData(recData), .recRegWrite(recRegWrite),
		.recPcWrite(recPcWrite), .recPcTarget(recPcTarget),
		.bufFree(bufFree), .bufRd(bufRd), .bufData(bufData), .bufRegWrite(bufRegWrite),
		.outReq(outReq), .outAck(outAck),
		.commitRd(commitRd), .commitData(commitData), .commitRegWrite(commitRegWrite),
		.pcWriteEnable(pcWriteEnable), .pcWriteData(pcWriteData),
		.wEn(wEn), .wAddr(wAddr), .wData(wData)
	);

endmodule

// File: src/instrIntake.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module instrIntake import execPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inReq,
	output logic inAck,
	input logic [`RV_OPW-1:0] opcode,
	input logic [2:0] func3,
	input logic [6:0] func7,
	input logic [`RV_REGW-1:0] rs1,
	input logic [`RV_REGW-1:0] rs2,
	input logic [`RV_REGW-1:0] rd,
	input logic [`RV_XLEN-1:0] imm,
	input logic [`RV_XLEN-1:0] pc,
	output logic issueValid,
	input logic issueTake,
	output aluOpT aluOp,
	output commitKindT kind,
	output logic useImm,
	output logic usePc,
	output logic [`RV_REGW-1:0] rs1Q,
	output logic [`RV_REGW-1:0] rs2Q,
	output logic [`RV_REGW-1:0] rdQ,
	output logic [`RV_XLEN-1:0] immQ,
	output logic [`RV_XLEN-1:0] pcQ
);

	aluOpT decOp;
	commitKindT decKind;
	logic decUseImm;
	logic decUsePc;
	logic capture;

	// only take a new instruction once the previous one is fully retired here
	assign capture = inReq && !inAck && !issueValid;

	always_comb
	begin
		decOp = aluAdd;
		decKind = kindNone;
		decUseImm = 1'b0;
		decUsePc = 1'b0;
		case (opcode)
			7'b0110011: // R format
			begin
				decKind = kindReg;
				case (func3)
					3'd0: decOp = func7[5] ? aluSub : aluAdd;
					3'd1: decOp = aluSll;
					3'd2: decOp = aluSlt;
					3'd3: decOp = aluSltu;
					3'd4: decOp = aluXor;
					3'd5: decOp = func7[5] ? aluSra : aluSrl;
					3'd6: decOp = aluOr;
					default: decOp = aluAnd;
				endcase
			end
			7'b0010011: // I format alu
			begin
				decKind = kindReg;
				decUseImm = 1'b1;
				case (func3)
					3'd0: decOp = aluAdd;
					3'd1: decOp = aluSll;
					3'd2: decOp = aluSlt;
					3'd3: decOp = aluSltu;
					3'd4: decOp = aluXor;
					3'd5: decOp = imm[10] ? aluSra : aluSrl; // srai vs srli
					3'd6: decOp = aluOr;
					default: decOp = aluAnd;
				endcase
			end
			7'b1100011: // branches
			begin
				decKind = kindBranch;
				case (func3)
					3'd0: decOp = aluEq;
					3'd1: decOp = aluNe;
					3'd4: decOp = aluSlt;
					3'd5: decOp = aluGe;
					3'd6: decOp = aluSltu;
					3'd7: decOp = aluGeu;
					default: decKind = kindNone; // reserved func3
				endcase
			end
			7'b1101111: // jal
			begin
				decKind = kindJal;
				decUsePc = 1'b1;
				decUseImm = 1'b1;
			end
			7'b1100111: // jalr
			begin
				decKind = kindJalr;
				decUseImm = 1'b1;
			end
			7'b0110111: decKind = kindLui;
			7'b0010111: // auipc
			begin
				decKind = kindReg;
				decUsePc = 1'b1;
				decUseImm = 1'b1;
			end
			default: decKind = kindNone;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inAck <= 1'b0;
			issueValid <= 1'b0;
		end
		else if (capture)
		begin
			inAck <= 1'b1;
			issueValid <= 1'b1;
		end
		else
		begin
			if (issueTake)
				issueValid <= 1'b0;
			if (inAck && !inReq && (!issueValid || issueTake))
				inAck <= 1'b0; // ack held until the core took it
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			aluOp <= decOp;
			kind <= decKind;
			useImm <= decUseImm;
			usePc <= decUsePc;
			rs1Q <= rs1;
			rs2Q <= rs2;
			rdQ <= rd;
			immQ <= imm;
			pcQ <= pc;
		end
	end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module regFile
(
	input logic clk,
	input logic reset,
	input logic [`RV_REGW-1:0] rAddr0,
	input logic [`RV_REGW-1:0] rAddr1,
	output logic [`RV_XLEN-1:0] rData0,
	output logic [`RV_XLEN-1:0] rData1,
	input logic wEn,
	input logic [`RV_REGW-1:0] wAddr,
	input logic [`RV_XLEN-1:0] wData
);

	logic [`RV_XLEN-1:0] regs [`RV_REGS];

	assign rData0 = regs[rAddr0]; // async read
	assign rData1 = regs[rAddr1];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `RV_REGS; i++)
				regs[i] <= '0;
		end
		else if (wEn && wAddr != '0)
			regs[wAddr] <= wData; // x0 never written
	end

endmodule

// File: src/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data and address width
`define RV_XLEN 32

`define RV_REGS 32 // architectural registers
`define RV_REGW 5 // register number width

`define RV_OPW 7 // opcode field

`endif

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (8) @(posedge clk);
		reset <= 1'b0; // released after 8 cycles
	end

endmodule

// File: test/execUnit_checker.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module execUnit_checker
(
	input logic clk,
	input logic reset,
	input logic inReq,
	input logic inAck,
	input logic outReq,
	input logic outAck,
	input logic [`RV_REGW-1:0] commitRd,
	input logic [`RV_XLEN-1:0] commitData,
	input logic commitRegWrite,
	input logic pcWriteEnable,
	input logic [`RV_XLEN-1:0] pcWriteData,
	input logic wEn
);

	ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(inAck) |-> $past(inReq))
		else $error("inAck rose while inReq was low");

	// record frozen until downstream answers
	recordStable: assert property (@(posedge clk) disable iff (reset)
		(outReq && !outAck) |=> $stable(commitRd) && $stable(commitData)
			&& $stable(commitRegWrite) && $stable(pcWriteEnable) && $stable(pcWriteData))
		else $error("commit record changed while outReq waited for outAck");

	reqFallsAfterAck: assert property (@(posedge clk) disable iff (reset)
		$fell(outReq) |-> $past(outAck))
		else $error("outReq fell without outAck");

	writeOnFirstAck: assert property (@(posedge clk) disable iff (reset)
		wEn |-> outReq && outAck && !$past(outAck))
		else $error("register write outside the first cycle of outAck");

endmodule

// File: test/execUnit_tb.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module execUnit_tb;

	localparam int maxVectors = 64;
	localparam int waitLimit = 200; // cycles per wait

	logic clk, reset;
	logic inReq, inAck, outReq, outAck;
	logic [`RV_OPW-1:0] opcode;
	logic [2:0] func3;
	logic [6:0] func7;
	logic [`RV_REGW-1:0] rs1, rs2, rd, commitRd;
	logic [`RV_XLEN-1:0] imm, pc, commitData, pcWriteData;
	logic commitRegWrite, pcWriteEnable;

	// one entry per vector line
	logic [`RV_OPW-1:0] vOpcode [maxVectors];
	logic [2:0] vFunc3 [maxVectors];
	logic [6:0] vFunc7 [maxVectors];
	logic [`RV_REGW-1:0] vRs1 [maxVectors];
	logic [`RV_REGW-1:0] vRs2 [maxVectors];
	logic [`RV_REGW-1:0] vRd [maxVectors];
	logic [`RV_XLEN-1:0] vImm [maxVectors];
	logic [`RV_XLEN-1:0] vPc [maxVectors];
	logic [`RV_REGW-1:0] eRd [maxVectors]; // expected record
	logic [`RV_XLEN-1:0] eData [maxVectors];
	logic eRegWrite [maxVectors];
	logic ePcWrite [maxVectors];
	logic [`RV_XLEN-1:0] ePcData [maxVectors];

	int vecCount = 0;
	int recordCount = 0;
	int errorCount = 0;
	int timeoutCount = 0;
	int seed = 63;
	logic hung = 1'b0; // set once any handshake times out

	clockGen clockGen_i (.clk(clk), .reset(reset));

	execUnit execUnit_i (
		.clk(clk), .reset(reset), .inReq(inReq), .inAck(inAck),
		.opcode(opcode), .func3(func3), .func7(func7),
		.rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .pc(pc),
		.outReq(outReq), .outAck(outAck),
		.commitRd(commitRd), .commitData(commitData), .commitRegWrite(commitRegWrite),
		.pcWriteEnable(pcWriteEnable), .pcWriteData(pcWriteData)
	);

	bind execUnit execUnit_checker checker_i (
		.clk(clk), .reset(reset), .inReq(inReq), .inAck(inAck),
		.outReq(outReq), .outAck(outAck),
		.commitRd(commitRd), .commitData(commitData), .commitRegWrite(commitRegWrite),
		.pcWriteEnable(pcWriteEnable), .pcWriteData(pcWriteData), .wEn(wEn)
	);

	// one count per completed output handshake
	always @(negedge clk)
	begin
		if (outReq && outAck)
			recordCount++;
	end

	task automatic compareData(input string name, input int idx,
		input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp);
		if (got !== exp)
		begin
			$display("** Error: %s record %0d got %h expected %h", name, idx, got, exp);
			errorCount++;
		end
	endtask

	task automatic compareReg(input string name, input int idx,
		input logic [`RV_REGW-1:0] got, input logic [`RV_REGW-1:0] exp);
		if (got !== exp)
		begin
			$display("** Error: %s record %0d got %h expected %h", name, idx, got, exp);
			errorCount++;
		end
	endtask

	task automatic compareFlag(input string name, input int idx, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("** Error: %s record %0d got %h expected %h", name, idx, got, exp);
			errorCount++;
		end
	endtask

	task automatic loadVectors();
		int fd;
		int fields;
		string line;
		fd = $fopen("test/exec_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("could not open test/exec_vectors.txt");
			errorCount++;
			return;
		end
		while (!$feof(fd) && vecCount < maxVectors)
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 8 || line.substr(0, 0) == "#")
				continue; // header and blank lines
			fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
				vOpcode[vecCount], vFunc3[vecCount], vFunc7[vecCount], vRs1[vecCount],
				vRs2[vecCount], vRd[vecCount], vImm[vecCount], vPc[vecCount],
				eRd[vecCount], eData[vecCount], eRegWrite[vecCount], ePcWrite[vecCount],
				ePcData[vecCount]);
			if (fields != 13)
			begin
				$display("malformed vector line: %s", line);
				errorCount++;
			end
			else
				vecCount++;
		end
		$fclose(fd);
	endtask

	task automatic waitInAck(input logic level);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (inAck !== level && !hung && cycles < waitLimit);
		if (inAck !== level && !hung)
		begin
			$display("input handshake hung: inAck did not reach %b in %0d cycles", level, waitLimit);
			timeoutCount++;
			hung = 1'b1;
		end
	endtask

	task automatic waitOutReq(input logic level);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (outReq !== level && !hung && cycles < waitLimit);
		if (outReq !== level && !hung)
		begin
			$display("output handshake hung: outReq did not reach %b in %0d cycles", level, waitLimit);
			timeoutCount++;
			hung = 1'b1;
		end
	endtask

	task automatic sendInstr(input int idx);
		waitInAck(1'b0);
		if (hung)
			return;
		@(posedge clk);
		opcode <= vOpcode[idx];
		func3 <= vFunc3[idx];
		func7 <= vFunc7[idx];
		rs1 <= vRs1[idx];
		rs2 <= vRs2[idx];
		rd <= vRd[idx];
		imm <= vImm[idx];
		pc <= vPc[idx];
		inReq <= 1'b1;
		waitInAck(1'b1);
		@(posedge clk);
		inReq <= 1'b0;
	endtask

	task automatic takeRecord(input int idx);
		int holdCycles;
		waitOutReq(1'b1);
		if (hung)
			return;
		compareReg("commitRd", idx, commitRd, eRd[idx]);
		compareData("commitData", idx, commitData, eData[idx]);
		compareFlag("commitRegWrite", idx, commitRegWrite, eRegWrite[idx]);
		compareFlag("pcWriteEnable", idx, pcWriteEnable, ePcWrite[idx]);
		compareData("pcWriteData", idx, pcWriteData, ePcData[idx]);
		holdCycles = $unsigned($random(seed)) % 6; // back-pressure 0 to 5 cycles
		repeat (holdCycles) @(posedge clk);
		@(posedge clk);
		outAck <= 1'b1;
		waitOutReq(1'b0);
		@(posedge clk);
		outAck <= 1'b0;
	endtask

	initial
	begin
		int cycles;
		inReq = 1'b0;
		outAck = 1'b0;
		opcode = '0;
		func3 = '0;
		func7 = '0;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		imm = '0;
		pc = '0;
		loadVectors();
		if (vecCount == 0)
		begin
			$display("no vectors were loaded");
			errorCount++;
		end
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (reset !== 1'b0 && cycles < waitLimit);
		if (reset !== 1'b0)
		begin
			$display("reset was never released");
			timeoutCount++;
			hung = 1'b1;
		end
		if (!hung)
		begin
			fork
				for (int i = 0; i < vecCount && !hung; i++)
					sendInstr(i);
				for (int j = 0; j < vecCount && !hung; j++)
					takeRecord(j);
			join
		end
		if (!hung)
		begin
			if (recordCount != vecCount)
			begin
				$display("** Error: record count got %h expected %h", recordCount, vecCount);
				errorCount++;
			end
			for (int k = 0; k < 10; k++)
			begin
				@(negedge clk);
				if (outReq)
				begin
					$display("an extra commit record appeared after the last vector");
					errorCount++;
					break;
				end
			end
		end
		$display("errors: %0d  timeouts: %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: test/exec_vectors.txt
# opcode func3 func7 rs1 rs2 rd imm pc | commitRd commitData commitRegWrite pcWriteEnable pcWriteData
# all fields hex, the last five columns are the expected commit record
13 0 00 00 00 01 0000007f 00000100 01 0000007f 1 0 00000000
13 0 00 00 00 02 fffffffd 00000104 02 fffffffd 1 0 00000000
33 0 00 01 02 03 00000000 00000108 03 0000007c 1 0 00000000
33 0 20 02 01 04 00000000 0000010c 04 ffffff7e 1 0 00000000
33 1 00 01 02 05 00000000 00000110 05 e0000000 1 0 00000000
33 2 00 02 01 06 00000000 00000114 06 00000001 1 0 00000000
33 3 00 02 01 07 00000000 00000118 07 00000000 1 0 00000000
33 4 00 01 02 08 00000000 0000011c 08 ffffff82 1 0 00000000
33 5 00 02 01 09 00000000 00000120 09 00000001 1 0 00000000
33 5 20 02 01 0a 00000000 00000124 0a ffffffff 1 0 00000000
33 6 00 01 02 0b 00000000 00000128 0b ffffffff 1 0 00000000
33 7 00 01 02 0c 00000000 0000012c 0c 0000007d 1 0 00000000
13 5 00 04 00 0d 00000404 00000130 0d fffffff7 1 0 00000000
13 5 00 04 00 0e 00000004 00000134 0e 0ffffff7 1 0 00000000
13 2 00 02 00 0f fffffffe 00000138 0f 00000001 1 0 00000000
13 3 00 01 00 10 00000080 0000013c 10 00000001 1 0 00000000
13 7 00 02 00 11 000000f0 00000140 11 000000f0 1 0 00000000
13 0 00 11 00 12 00000001 00000144 12 000000f1 1 0 00000000
33 0 00 12 12 12 00000000 00000148 12 000001e2 1 0 00000000
63 0 00 01 01 00 00000010 0000014c 00 00000000 0 1 0000015c
63 0 00 01 02 00 00000010 00000150 00 00000000 0 0 00000160
63 1 00 01 02 00 00000010 00000154 00 00000000 0 1 00000164
63 1 00 02 02 00 00000010 00000158 00 00000000 0 0 00000168
63 4 00 02 01 00 fffffff0 0000015c 00 00000000 0 1 0000014c
63 4 00 01 02 00 fffffff0 00000160 00 00000000 0 0 00000150
63 5 00 01 02 00 00000010 00000164 00 00000000 0 1 00000174
63 5 00 02 01 00 00000010 00000168 00 00000000 0 0 00000178
63 6 00 01 02 00 00000010 0000016c 00 00000000 0 1 0000017c
63 6 00 02 01 00 00000010 00000170 00 00000000 0 0 00000180
63 7 00 02 01 00 00000010 00000174 00 00000000 0 1 00000184
63 7 00 01 02 00 00000010 00000178 00 00000000 0 0 00000188
6f 0 00 00 00 13 00000020 0000017c 13 00000180 1 1 0000019c
67 0 00 01 00 14 00000002 00000180 14 00000184 1 1 00000080
37 0 00 00 00 15 12345000 00000184 15 12345000 1 0 00000000
17 0 00 00 00 16 00001000 00000188 16 00001188 1 0 00000000
13 0 00 01 00 00 00000005 0000018c 00 00000084 0 0 00000000
33 0 00 00 01 17 00000000 00000190 17 0000007f 1 0 00000000
03 2 00 01 00 05 00000008 00000194 00 00000000 0 0 00000000
67 0 00 17 00 18 00000001 00000198 18 0000019c 1 1 00000080

// File: vlog.f
+incdir+src
src/execPkg.sv
src/instrIntake.sv
src/regFile.sv
src/aluUnit.sv
src/execCore.sv
src/commitPort.sv
src/execUnit.sv
test/clockGen.sv
test/execUnit_checker.sv
test/execUnit_tb.sv
